// ==== design/rv_exec_pkg.sv ====
package rv_exec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
        ALU_SRA, ALU_OR, ALU_AND, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;   // also shamt for immediate shifts
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    // branch offset is scattered over two fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] upper;   // U immediate, or the shuffled J immediate
        reg_addr_t   rd;
        opcode_e     opcode;
    } uj_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        i_fmt_t  i;
        b_fmt_t  b;
        uj_fmt_t uj;
    } inst_u;

endpackage

// ==== design/dec_ex_if.sv ====
`timescale 1ns/1ps

interface dec_ex_if;
    import rv_exec_pkg::*;

    logic      valid;
    alu_op_e   alu_op;
    br_op_e    br_op;
    word_t     op1;
    word_t     op2;
    word_t     jmp_base;   // target = base + off
    word_t     jmp_off;
    reg_addr_t rd;
    logic      rd_we;

    modport dec (
        output valid, alu_op, br_op, op1, op2, jmp_base, jmp_off, rd, rd_we
    );

    modport ex (
        input valid, alu_op, br_op, op1, op2, jmp_base, jmp_off, rd, rd_we
    );

endinterface

// ==== design/ex_res_if.sv ====
`timescale 1ns/1ps

interface ex_res_if;
    import rv_exec_pkg::*;

    logic      valid;
    reg_addr_t rd;
    logic      rd_we;
    word_t     wdata;
    logic      jump;
    word_t     jump_addr;   // zero unless taken

    modport ex (
        output valid, rd, rd_we, wdata, jump, jump_addr
    );

    modport res (
        input valid, rd, rd_we, wdata, jump, jump_addr
    );

endinterface

// ==== design/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  rv_exec_pkg::alu_op_e alu_op_i,
    input  rv_exec_pkg::word_t   op1_i,
    input  rv_exec_pkg::word_t   op2_i,
    output rv_exec_pkg::word_t   result_o
);
    import rv_exec_pkg::*;

    logic [4:0]          shamt;
    word_t               op1_neg;
    word_t               op2_neg;
    word_t               mul_a;
    word_t               mul_b;
    logic [2*XLEN-1:0]   prod;
    logic [2*XLEN-1:0]   prod_neg;
    logic                prod_flip;
    logic                signed_mul1;
    logic                signed_mul2;

    assign shamt = op2_i[4:0];

    assign op1_neg = ~op1_i + 1'b1;
    assign op2_neg = ~op2_i + 1'b1;

    // signed high multiplies run on magnitudes
    assign signed_mul1 = (alu_op_i == ALU_MULH) || (alu_op_i == ALU_MULHSU);
    assign signed_mul2 = (alu_op_i == ALU_MULH);

    assign mul_a = (signed_mul1 && op1_i[XLEN-1]) ? op1_neg : op1_i;
    assign mul_b = (signed_mul2 && op2_i[XLEN-1]) ? op2_neg : op2_i;

    assign prod     = {{XLEN{1'b0}}, mul_a} * {{XLEN{1'b0}}, mul_b};
    assign prod_neg = ~prod + 1'b1;

    // result sign differs from the magnitude product
    always_comb begin
        if (alu_op_i == ALU_MULH) begin
            prod_flip = op1_i[XLEN-1] ^ op2_i[XLEN-1];
        end else if (alu_op_i == ALU_MULHSU) begin
            prod_flip = op1_i[XLEN-1];
        end else begin
            prod_flip = 1'b0;
        end
    end

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = op1_i + op2_i;
            ALU_SUB:    result_o = op1_i - op2_i;
            ALU_SLL:    result_o = op1_i << shamt;
            ALU_SLT:    result_o = {31'h0, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU:   result_o = {31'h0, op1_i < op2_i};
            ALU_XOR:    result_o = op1_i ^ op2_i;
            ALU_SRL:    result_o = op1_i >> shamt;
            ALU_SRA:    result_o = $signed(op1_i) >>> shamt;
            ALU_OR:     result_o = op1_i | op2_i;
            ALU_AND:    result_o = op1_i & op2_i;
            ALU_MUL:    result_o = prod[XLEN-1:0];
            ALU_MULH,
            ALU_MULHSU: result_o = prod_flip ? prod_neg[2*XLEN-1:XLEN] : prod[2*XLEN-1:XLEN];
            ALU_MULHU:  result_o = prod[2*XLEN-1:XLEN];
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode #(
    parameter bit MUL_EN = 1'b1
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                valid_i,
    input  rv_exec_pkg::word_t  inst_i,
    input  rv_exec_pkg::word_t  pc_i,
    input  rv_exec_pkg::word_t  rs1_data_i,
    input  rv_exec_pkg::word_t  rs2_data_i,
    dec_ex_if.dec               dec_o
);
    import rv_exec_pkg::*;

    inst_u      inst;
    logic [6:0] funct7;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_e    alu_op_c;
    br_op_e     br_op_c;
    word_t      op1_c;
    word_t      op2_c;
    word_t      base_c;
    word_t      off_c;
    logic       rd_we_c;

    assign inst   = inst_i;
    assign funct7 = inst.r.funct7;
    assign funct3 = inst.r.funct3;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.uj.upper, 12'h000};
    assign imm_j = {{12{inst.uj.upper[19]}}, inst.uj.upper[7:0], inst.uj.upper[8],
                    inst.uj.upper[18:9], 1'b0};

    always_comb begin
        alu_op_c = ALU_ADD;
        br_op_c  = BR_NONE;
        op1_c    = '0;
        op2_c    = '0;
        base_c   = '0;
        off_c    = '0;
        rd_we_c  = 1'b0;
        case (inst.r.opcode)
            OPC_OP_IMM: begin
                op1_c   = rs1_data_i;
                op2_c   = imm_i;
                rd_we_c = 1'b1;
                case (funct3)
                    3'b000: alu_op_c = ALU_ADD;
                    3'b001: begin
                        alu_op_c = ALU_SLL;
                        op2_c    = {27'h0, inst.r.rs2};   // shamt
                    end
                    3'b010: alu_op_c = ALU_SLT;
                    3'b011: alu_op_c = ALU_SLTU;
                    3'b100: alu_op_c = ALU_XOR;
                    3'b101: begin
                        alu_op_c = funct7[5] ? ALU_SRA : ALU_SRL;
                        op2_c    = {27'h0, inst.r.rs2};
                    end
                    3'b110: alu_op_c = ALU_OR;
                    default: alu_op_c = ALU_AND;
                endcase
            end
            OPC_OP: begin
                op1_c = rs1_data_i;
                op2_c = rs2_data_i;
                if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                    rd_we_c = 1'b1;
                    case (funct3)
                        3'b000: alu_op_c = funct7[5] ? ALU_SUB : ALU_ADD;
                        3'b001: alu_op_c = ALU_SLL;
                        3'b010: alu_op_c = ALU_SLT;
                        3'b011: alu_op_c = ALU_SLTU;
                        3'b100: alu_op_c = ALU_XOR;
                        3'b101: alu_op_c = funct7[5] ? ALU_SRA : ALU_SRL;
                        3'b110: alu_op_c = ALU_OR;
                        default: alu_op_c = ALU_AND;
                    endcase
                end else if (MUL_EN && funct7 == 7'b0000001) begin
                    rd_we_c = ~funct3[2];   // div/rem not supported
                    case (funct3)
                        3'b000: alu_op_c = ALU_MUL;
                        3'b001: alu_op_c = ALU_MULH;
                        3'b010: alu_op_c = ALU_MULHSU;
                        3'b011: alu_op_c = ALU_MULHU;
                        default: alu_op_c = ALU_ADD;
                    endcase
                end
            end
            OPC_LUI: begin
                op2_c   = imm_u;
                rd_we_c = 1'b1;
            end
            OPC_AUIPC: begin
                op1_c   = pc_i;
                op2_c   = imm_u;
                rd_we_c = 1'b1;
            end
            OPC_JAL: begin
                op1_c   = pc_i;
                op2_c   = 32'd4;   // link value
                base_c  = pc_i;
                off_c   = imm_j;
                br_op_c = BR_ALWAYS;
                rd_we_c = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op1_c   = pc_i;
                    op2_c   = 32'd4;
                    base_c  = rs1_data_i;   // bit 0 kept as is
                    off_c   = imm_i;
                    br_op_c = BR_ALWAYS;
                    rd_we_c = 1'b1;
                end
            end
            OPC_BRANCH: begin
                op1_c  = rs1_data_i;
                op2_c  = rs2_data_i;
                base_c = pc_i;
                off_c  = imm_b;
                case (funct3)
                    3'b000: br_op_c = BR_EQ;
                    3'b001: br_op_c = BR_NE;
                    3'b100: br_op_c = BR_LT;
                    3'b101: br_op_c = BR_GE;
                    3'b110: br_op_c = BR_LTU;
                    3'b111: br_op_c = BR_GEU;
                    default: br_op_c = BR_NONE;
                endcase
            end
            default: ;   // unknown opcode, passes as a bubble with valid set
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_o.valid <= 1'b0;
            dec_o.rd_we <= 1'b0;
            dec_o.br_op <= BR_NONE;
        end else begin
            dec_o.valid <= valid_i;
            dec_o.rd_we <= valid_i & rd_we_c;
            dec_o.br_op <= valid_i ? br_op_c : BR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        dec_o.alu_op   <= alu_op_c;
        dec_o.op1      <= op1_c;
        dec_o.op2      <= op2_c;
        dec_o.jmp_base <= base_c;
        dec_o.jmp_off  <= off_c;
        dec_o.rd       <= inst.r.rd;
    end

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    dec_ex_if.ex dec_i,
    ex_res_if.ex res_o
);
    import rv_exec_pkg::*;

    word_t alu_res;
    word_t target;
    logic  op_eq;
    logic  op_lt_s;
    logic  op_lt_u;
    logic  taken;

    rv_alu u_alu (
        .alu_op_i (dec_i.alu_op),
        .op1_i    (dec_i.op1),
        .op2_i    (dec_i.op2),
        .result_o (alu_res)
    );

    assign op_eq   = (dec_i.op1 == dec_i.op2);
    assign op_lt_s = $signed(dec_i.op1) < $signed(dec_i.op2);
    assign op_lt_u = dec_i.op1 < dec_i.op2;

    always_comb begin
        case (dec_i.br_op)
            BR_EQ:     taken = op_eq;
            BR_NE:     taken = ~op_eq;
            BR_LT:     taken = op_lt_s;
            BR_GE:     taken = ~op_lt_s;
            BR_LTU:    taken = op_lt_u;
            BR_GEU:    taken = ~op_lt_u;
            BR_ALWAYS: taken = 1'b1;   // jal / jalr
            default:   taken = 1'b0;
        endcase
    end

    assign target = dec_i.jmp_base + dec_i.jmp_off;

    assign res_o.valid     = dec_i.valid;
    assign res_o.rd        = dec_i.rd;
    assign res_o.rd_we     = dec_i.rd_we;
    assign res_o.wdata     = dec_i.rd_we ? alu_res : '0;   // zero for non-writing items
    assign res_o.jump      = taken;
    assign res_o.jump_addr = taken ? target : '0;

endmodule

// ==== design/rv_result.sv ====
`timescale 1ns/1ps

module rv_result (
    input  logic                   clk,
    input  logic                   arst_n_i,
    ex_res_if.res                  res_i,
    output logic                   valid_o,
    output logic                   rd_we_o,
    output rv_exec_pkg::reg_addr_t rd_addr_o,
    output rv_exec_pkg::word_t     rd_wdata_o,
    output logic                   jump_o,
    output rv_exec_pkg::word_t     jump_addr_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            rd_we_o     <= 1'b0;
            jump_o      <= 1'b0;
            rd_addr_o   <= '0;
            rd_wdata_o  <= '0;
            jump_addr_o <= '0;
        end else begin
            valid_o <= res_i.valid;
            rd_we_o <= res_i.valid & res_i.rd_we & (res_i.rd != '0);   // x0 never written
            jump_o  <= res_i.valid & res_i.jump;
            if (res_i.valid) begin
                rd_addr_o   <= res_i.rd;
                rd_wdata_o  <= res_i.wdata;
                jump_addr_o <= res_i.jump_addr;
            end
        end
    end

endmodule

// ==== design/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top #(
    parameter bit MUL_EN = 1'b1
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   valid_i,
    input  rv_exec_pkg::word_t     inst_i,
    input  rv_exec_pkg::word_t     pc_i,
    input  rv_exec_pkg::word_t     rs1_data_i,
    input  rv_exec_pkg::word_t     rs2_data_i,
    output logic                   valid_o,
    output logic                   rd_we_o,
    output rv_exec_pkg::reg_addr_t rd_addr_o,
    output rv_exec_pkg::word_t     rd_wdata_o,
    output logic                   jump_o,
    output rv_exec_pkg::word_t     jump_addr_o
);

    dec_ex_if dec_ex ();
    ex_res_if ex_res ();

    // stage 1, registered
    rv_decode #(
        .MUL_EN (MUL_EN)
    ) u_decode (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .valid_i    (valid_i),
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .dec_o      (dec_ex.dec)
    );

    rv_execute u_execute (
        .dec_i (dec_ex.ex),
        .res_o (ex_res.ex)
    );

    // stage 2, registered
    rv_result u_result (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .res_i       (ex_res.res),
        .valid_o     (valid_o),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_wdata_o  (rd_wdata_o),
        .jump_o      (jump_o),
        .jump_addr_o (jump_addr_o)
    );

endmodule

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic      rd_we;
    reg_addr_t rd;
    word_t     wdata;
    logic      jump;
    word_t     jump_addr;
} exp_t;

function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3, input reg_addr_t rd);
    return {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                input reg_addr_t rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
endfunction

function automatic word_t enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd, input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// alt picks sub or arithmetic shift
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// operands sign or zero extended to 64 bits
function automatic word_t mul_ref(input logic [2:0] f3, input word_t a, input word_t b);
    logic [63:0] sa;
    logic [63:0] ua;
    logic [63:0] sb;
    logic [63:0] ub;
    logic [63:0] p;
    sa = {{32{a[31]}}, a};
    ua = {32'h0, a};
    sb = {{32{b[31]}}, b};
    ub = {32'h0, b};
    case (f3[1:0])
        2'd0: p = ua * ub;
        2'd1: p = sa * sb;
        2'd2: p = sa * ub;
        default: p = ua * ub;
    endcase
    return (f3[1:0] == 2'd0) ? p[31:0] : p[63:32];
endfunction

function automatic exp_t ref_exec(input word_t inst, input word_t pc,
                                  input word_t a, input word_t b);
    exp_t       e;
    logic [6:0] f7;
    logic [2:0] f3;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      res;
    logic       we;
    logic       taken;
    f7    = inst[31:25];
    f3    = inst[14:12];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    e     = '0;
    e.rd  = inst[11:7];
    we    = 1'b0;
    res   = '0;
    case (inst[6:0])
        OPC_OP_IMM: begin
            we  = 1'b1;
            res = alu_ref(f3, f3 == 3'd5 && inst[30], a, imm_i);   // shamt is imm low bits
        end
        OPC_OP: begin
            if (f7 == 7'h00 || f7 == 7'h20) begin
                we  = 1'b1;
                res = alu_ref(f3, inst[30], a, b);
            end else if (f7 == 7'h01 && !f3[2]) begin
                we  = 1'b1;
                res = mul_ref(f3, a, b);
            end
        end
        OPC_LUI: begin
            we  = 1'b1;
            res = {inst[31:12], 12'h000};
        end
        OPC_AUIPC: begin
            we  = 1'b1;
            res = pc + {inst[31:12], 12'h000};
        end
        OPC_JAL: begin
            we          = 1'b1;
            res         = pc + 32'd4;
            e.jump      = 1'b1;
            e.jump_addr = pc + imm_j;
        end
        OPC_JALR: begin
            if (f3 == 3'd0) begin
                we          = 1'b1;
                res         = pc + 32'd4;
                e.jump      = 1'b1;
                e.jump_addr = a + imm_i;   // bit 0 not cleared
            end
        end
        OPC_BRANCH: begin
            case (f3)
                3'd0: taken = (a == b);
                3'd1: taken = (a != b);
                3'd4: taken = $signed(a) < $signed(b);
                3'd5: taken = $signed(a) >= $signed(b);
                3'd6: taken = a < b;
                3'd7: taken = a >= b;
                default: taken = 1'b0;
            endcase
            e.jump      = taken;
            e.jump_addr = taken ? pc + imm_b : '0;
        end
        default: ;
    endcase
    e.rd_we = we && (e.rd != 5'd0);
    e.wdata = res;
    return e;
endfunction

`endif

// ==== testbench/tb_rv_exec.sv ====
`timescale 1ns/1ps

module tb_rv_exec;
    import rv_exec_pkg::*;

    `include "tb_ref_model.svh"

    localparam logic [31:0] SEED = 32'hefc4ad28;
    localparam int N_RAND     = 200;
    localparam int N_MUL_RAND = 25;
    localparam int N_MIX      = 60;
    localparam int N_TESTS    = 6;
    localparam int N_TOTAL    = 4 + 2 * N_RAND + 16 * 4 + 4 * N_MUL_RAND + 22 + N_MIX;
    localparam int TIMEOUT    = N_TOTAL + 20 * N_TESTS;

    logic      clk;
    logic      arst_n_i;
    logic      valid_i;
    word_t     inst_i;
    word_t     pc_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    logic      valid_o;
    logic      rd_we_o;
    reg_addr_t rd_addr_o;
    word_t     rd_wdata_o;
    logic      jump_o;
    word_t     jump_addr_o;

    exp_t exp_q[$];
    int   due_q[$];   // cycle at which each output is expected
    int   cyc = 0;
    int   err_cnt = 0;
    int   chk_cnt = 0;
    int   test_err = 0;
    int   test_chk = 0;

    rv_exec_top #(
        .MUL_EN (1'b1)
    ) UUT (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .valid_o     (valid_o),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_wdata_o  (rd_wdata_o),
        .jump_o      (jump_o),
        .jump_addr_o (jump_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin : watchdog
        wait (cyc >= TIMEOUT);
        $display("timeout: outputs stopped arriving before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_val(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("ERR %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    function automatic word_t rand_word();
        logic [31:0] r;
        r = $urandom;
        case (r[2:0])
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    task automatic send(input word_t inst, input word_t pc, input word_t a, input word_t b);
        @(posedge clk);
        valid_i    <= 1'b1;
        inst_i     <= inst;
        pc_i       <= pc;
        rs1_data_i <= a;
        rs2_data_i <= b;
        exp_q.push_back(ref_exec(inst, pc, a, b));
        due_q.push_back(cyc + 3);   // two edges after the drive edge
    endtask

    task automatic idle();
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        idle();
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
        $display("%-26s %4d outputs, %0d errors", name, chk_cnt - test_chk, err_cnt - test_err);
        test_chk = chk_cnt;
        test_err = err_cnt;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        exp_t e;
        int   due;
        if (arst_n_i && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("an output arrived with no instruction pending");
                err_cnt++;
            end else begin
                e   = exp_q.pop_front();
                due = due_q.pop_front();
                assert (cyc == due) else begin
                    $display("valid_o arrived at cycle %0d instead of cycle %0d", cyc, due);
                    err_cnt++;
                end
                check_val("rd_we_o", e.rd_we, rd_we_o);
                check_val("rd_addr_o", e.rd, rd_addr_o);
                if (e.rd_we) check_val("rd_wdata_o", e.wdata, rd_wdata_o);
                check_val("jump_o", e.jump, jump_o);
                if (e.jump) check_val("jump_addr_o", e.jump_addr, jump_addr_o);
                chk_cnt++;
            end
        end else if (arst_n_i) begin
            assert (!rd_we_o && !jump_o) else begin
                $display("a write or jump was raised while valid_o was low");
                err_cnt++;
            end
        end
    end

    initial begin : stimulus
        word_t       r;
        word_t       pc;
        word_t       corner [4];
        logic [2:0]  f3;
        logic [11:0] imm;
        r          = $urandom(SEED);
        arst_n_i   = 1'b0;
        valid_i    = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        corner[0]  = 32'h8000_0000;
        corner[1]  = 32'hffff_ffff;
        corner[2]  = 32'h0000_0001;
        corner[3]  = 32'h7fff_ffff;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;

        repeat (2) @(negedge clk);
        check_val("valid_o", 32'd0, valid_o);
        check_val("rd_we_o", 32'd0, rd_we_o);
        check_val("jump_o", 32'd0, jump_o);
        check_val("rd_wdata_o", 32'd0, rd_wdata_o);
        check_val("jump_addr_o", 32'd0, jump_addr_o);
        for (int n = 0; n < 4; n++) begin
            send(enc_i(12'h010 + n[11:0], 3'd0, 5'd3, OPC_OP_IMM), 32'h100, rand_word(), 0);
            idle();
        end
        finish_test("reset and latency");

        for (int n = 0; n < N_RAND; n++) begin
            r  = $urandom;
            f3 = r[2:0];
            send(enc_r((r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, f3, r[8:4]),
                 32'h0, rand_word(), rand_word());
        end
        finish_test("r-type alu");

        for (int n = 0; n < N_RAND; n++) begin
            r   = $urandom;
            f3  = r[2:0];
            imm = r[31:20];
            if (f3 == 3'd1) imm = {7'h00, r[24:20]};
            if (f3 == 3'd5) imm = {r[3] ? 7'h20 : 7'h00, r[24:20]};   // srai or srli
            send(enc_i(imm, f3, r[8:4], OPC_OP_IMM), 32'h0, rand_word(), 0);
        end
        finish_test("op-imm alu");

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                for (int k = 0; k < 4; k++) begin
                    send(enc_r(7'h01, k[2:0], 5'd7), 32'h0, corner[i], corner[j]);
                end
            end
        end
        for (int n = 0; n < N_MUL_RAND; n++) begin
            for (int k = 0; k < 4; k++) begin
                send(enc_r(7'h01, k[2:0], 5'd9), 32'h0, rand_word(), rand_word());
            end
        end
        finish_test("multiply");

        // equal, signed greater and signed less pairs
        for (int i = 0; i < 6; i++) begin
            f3 = (i < 2) ? i[2:0] : i[2:0] + 3'd2;
            for (int k = 0; k < 3; k++) begin
                r  = $urandom;
                pc = $urandom & 32'hffff_fffc;
                send(enc_b({r[12:1], 1'b0}, f3), pc, (k == 2) ? 32'hffff_fffd : 32'd5,
                     (k == 1) ? 32'hffff_fffd : 32'd5);
            end
        end
        r  = $urandom;
        pc = $urandom & 32'hffff_fffc;
        send(enc_j({r[20:1], 1'b0}, 5'd1), pc, 0, 0);
        send(enc_i(r[31:20], 3'd0, 5'd1, OPC_JALR), pc, rand_word(), 0);
        send(enc_u(r[19:0], 5'd5, OPC_LUI), pc, 0, 0);
        send(enc_u(r[31:12], 5'd6, OPC_AUIPC), pc, 0, 0);
        finish_test("branch and jump");

        for (int n = 0; n < N_MIX; n++) begin
            r  = $urandom;
            pc = $urandom & 32'hffff_fffc;
            case (r[1:0])
                2'd0: send(enc_r(7'h00, r[4:2], 5'd0), pc, rand_word(), rand_word());
                2'd1: send({r[31:7], 7'b0000011}, pc, rand_word(), rand_word());   // load opcode
                2'd2: send(enc_r(7'h10, r[4:2], r[12:8]), pc, rand_word(), rand_word());
                default: send(enc_i(r[31:20], 3'd0, r[12:8] | 5'd1, OPC_OP_IMM), pc,
                              rand_word(), 0);
            endcase
        end
        finish_test("mixed stream");

        $display("%0d outputs checked over %0d tests, %0d errors", chk_cnt, N_TESTS, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_exec.f ====
+incdir+include
design/rv_exec_pkg.sv
design/dec_ex_if.sv
design/ex_res_if.sv
design/rv_alu.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_exec_top.sv
testbench/tb_rv_exec.sv
